// ==== pkt_match_pkg.sv ====
`default_nettype none

package pkt_match_pkg;

  // Data word geometry
  localparam int word_bytes = 8;
  localparam int byte_w = 8;
  localparam int data_w = word_bytes * byte_w;

  // Length code is valid bytes minus one, valid bytes sit at the low end
  localparam int len_w = 3;
  localparam logic [len_w-1:0] len_full = 3'd7;

  // Word index within a packet, up to 16 words
  localparam int word_off_w = 4;
  // Byte index within a word
  localparam int byte_off_w = $clog2(word_bytes);

  // Type field, never straddles two words
  localparam int type_bytes = 4;
  localparam int type_w = type_bytes * byte_w;
  localparam int type_last_start = word_bytes - type_bytes;

  // Symbol match table
  localparam int num_symbols = 4;
  localparam int buffer_w = 16;

  // Packet FSM encoding
  localparam logic st_idle = 1'b0;
  localparam logic st_in_packet = 1'b1;

  // One data word, seen as bytes by the type matcher
  // and as a single 64-bit symbol by the symbol matcher
  typedef union packed {
    logic [word_bytes-1:0][byte_w-1:0] bytes;
    logic [data_w-1:0]                 symbol;
  } data_word_u;

  // Unary mask of the valid bytes for a length code
  function automatic logic [word_bytes-1:0] len_mask(input logic [len_w-1:0] len);
    logic [word_bytes-1:0] mask;
    mask = '0;
    for (int i = 0; i < word_bytes; i++) begin
      mask[i] = (i <= int'(len));
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// ==== match_word_if.sv ====
`default_nettype none

interface match_word_if;
  import pkt_match_pkg::*;

  // Registered input word
  logic             vld;
  logic             sop;
  logic             eop;
  logic [len_w-1:0] length;
  data_word_u       data;

  // Parse status of the registered word
  logic [word_off_w-1:0] word_off;
  logic                  can_match;
  logic                  buffer_set;
  // Operand capture at the next edge
  logic                  load;

  modport ctrl (output vld, sop, eop, length, data, word_off, can_match, buffer_set, load);
  modport matcher (input vld, length, data, word_off, load);
  modport tracker (input sop, eop, length, data, can_match, buffer_set, load);

endinterface

`default_nettype wire

// ==== pkt_parse_ctrl.sv ====
`default_nettype none

module pkt_parse_ctrl (
  input  logic                                clk_net,
  input  logic                                rst_net,
  input  logic                                in_vld,
  input  logic                                in_sop,
  input  logic                                in_eop,
  input  logic [pkt_match_pkg::len_w-1:0]     in_length,
  input  logic [pkt_match_pkg::data_w-1:0]    in_data,
  match_word_if.ctrl                          word
);
  import pkt_match_pkg::*;

  logic state_r;
  logic state_nxt;
  logic accept;
  logic last;

  // Operands are loaded one cycle ahead of the start word reaching the register
  assign word.load = in_vld & in_sop;

  // Input valid, the only control bit of the input register
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      word.vld <= 1'b0;
    end else begin
      word.vld <= in_vld;
    end
  end

  // Payload only captured on valid input
  always_ff @(posedge clk_net) begin
    if (in_vld) begin
      word.sop    <= in_sop;
      word.eop    <= in_eop;
      word.length <= in_length;
      word.data   <= in_data;
    end
  end

  // Packet FSM
  always_comb begin
    state_nxt = state_r;
    accept    = 1'b0;
    last      = 1'b0;
    case (state_r)
      st_idle: begin
        // Only a start word opens a packet, anything else is dropped
        if (word.vld && word.sop) begin
          accept = 1'b1;
          if (word.eop) begin
            // One-word packet, stay idle
            last = 1'b1;
          end else begin
            state_nxt = st_in_packet;
          end
        end
      end
      default: begin
        // Inside a packet every valid word belongs to it
        if (word.vld) begin
          accept = 1'b1;
          if (word.eop) begin
            last      = 1'b1;
            state_nxt = st_idle;
          end
        end
      end
    endcase
  end

  assign word.can_match  = accept;
  assign word.buffer_set = last;

  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      state_r <= st_idle;
    end else begin
      state_r <= state_nxt;
    end
  end

  // Word index, restarted by operand load
  always_ff @(posedge clk_net) begin
    if (rst_net || word.load) begin
      word.word_off <= '0;
    end else if (accept && !last) begin
      word.word_off <= word.word_off + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== type_matcher.sv ====
`default_nettype none

module type_matcher (
  input  logic                                  clk_net,
  match_word_if.matcher                         word,
  input  logic [pkt_match_pkg::word_off_w-1:0]  type_word_off,
  input  logic [pkt_match_pkg::byte_off_w-1:0]  type_byte_off,
  input  logic [pkt_match_pkg::type_w-1:0]      type_value,
  output logic                                  type_found
);
  import pkt_match_pkg::*;

  // Latched operands, type byte 0 at the low end
  logic [word_off_w-1:0]            word_off_r;
  logic [byte_off_w-1:0]            byte_off_r;
  logic [type_bytes-1:0][byte_w-1:0] type_r;

  logic [word_bytes-1:0]      valid_mask;
  logic [type_last_start:0]   window_eq;
  logic                       off_in_range;

  always_ff @(posedge clk_net) begin
    if (word.load) begin
      word_off_r <= type_word_off;
      byte_off_r <= type_byte_off;
      type_r     <= type_value;
    end
  end

  always_comb begin
    valid_mask = len_mask(word.length);
    // One comparator window per legal start byte, 0 to 4
    for (int i = 0; i <= type_last_start; i++) begin
      window_eq[i] = 1'b1;
      for (int j = 0; j < type_bytes; j++) begin
        // Bytes past the word length never match
        window_eq[i] &= valid_mask[i+j] & (type_r[j] == word.data.bytes[i+j]);
      end
    end
  end

  // Start offsets above 4 would straddle into the next word
  assign off_in_range = (int'(byte_off_r) <= type_last_start);

  assign type_found = word.vld && (word.word_off == word_off_r) && off_in_range &&
                      window_eq[byte_off_r];

endmodule

`default_nettype wire

// ==== symbol_matcher.sv ====
`default_nettype none

module symbol_matcher (
  input  logic                                                        clk_net,
  match_word_if.matcher                                               word,
  input  logic [pkt_match_pkg::num_symbols-1:0]                       sym_valid,
  input  logic [pkt_match_pkg::num_symbols-1:0][pkt_match_pkg::word_off_w-1:0] sym_word_off,
  input  logic [pkt_match_pkg::num_symbols-1:0][pkt_match_pkg::data_w-1:0]     sym_value,
  input  logic [pkt_match_pkg::num_symbols-1:0][pkt_match_pkg::buffer_w-1:0]   sym_buffer,
  output logic                                                        sym_found,
  output logic [pkt_match_pkg::buffer_w-1:0]                          sym_buffer_sel
);
  import pkt_match_pkg::*;

  // Latched match table
  logic [num_symbols-1:0]                 valid_r;
  logic [num_symbols-1:0][word_off_w-1:0] word_off_r;
  logic [num_symbols-1:0][data_w-1:0]     value_r;
  logic [num_symbols-1:0][buffer_w-1:0]   buffer_r;

  logic                   full_word;
  logic [num_symbols-1:0] hit;

  always_ff @(posedge clk_net) begin
    if (word.load) begin
      valid_r    <= sym_valid;
      word_off_r <= sym_word_off;
      value_r    <= sym_value;
      buffer_r   <= sym_buffer;
    end
  end

  // A symbol fills the whole word
  assign full_word = word.vld && (word.length == len_full);

  always_comb begin
    sym_buffer_sel = '0;
    for (int i = 0; i < num_symbols; i++) begin
      // Entry must be enabled and tied to this word index
      hit[i] = full_word && valid_r[i] && (word_off_r[i] == word.word_off) &&
               (word.data.symbol == value_r[i]);
      // Later entries overwrite, so the highest index wins
      if (hit[i]) begin
        sym_buffer_sel = buffer_r[i];
      end
    end
  end

  // Explicit flag so a zero buffer still counts as a hit
  assign sym_found = |hit;

endmodule

`default_nettype wire

// ==== match_tracker.sv ====
`default_nettype none

module match_tracker (
  input  logic                                clk_net,
  input  logic                                rst_net,
  match_word_if.tracker                       word,
  input  logic                                type_found,
  input  logic                                sym_found,
  input  logic [pkt_match_pkg::buffer_w-1:0]  sym_buffer,
  output logic                                out_vld,
  output logic                                out_sop,
  output logic                                out_eop,
  output logic [pkt_match_pkg::len_w-1:0]     out_length,
  output pkt_match_pkg::data_word_u           out_data,
  output logic [pkt_match_pkg::buffer_w-1:0]  out_buffer
);
  import pkt_match_pkg::*;

  // Match state retained across the words of a packet
  logic                got_type_r;
  logic                got_symbol_r;
  logic [buffer_w-1:0] buffer_r;

  // Retained state merged with the current word
  logic                type_now;
  logic                symbol_now;
  logic                got_type;
  logic                got_symbol;
  logic [buffer_w-1:0] buffer_comb;
  logic [buffer_w-1:0] buffer_out;

  // Matches only count on accepted words
  assign type_now   = word.can_match & type_found;
  assign symbol_now = word.can_match & sym_found;

  assign got_type    = got_type_r | type_now;
  assign got_symbol  = got_symbol_r | symbol_now;
  assign buffer_comb = symbol_now ? sym_buffer : buffer_r;

  // Buffer only released on the end word with both matches seen
  assign buffer_out = (word.buffer_set && got_type && got_symbol) ? buffer_comb : '0;

  // Load clears ahead of the start word, it takes priority over updates
  always_ff @(posedge clk_net) begin
    if (rst_net || word.load) begin
      got_type_r   <= 1'b0;
      got_symbol_r <= 1'b0;
    end else begin
      got_type_r   <= got_type;
      got_symbol_r <= got_symbol;
    end
  end

  // Newest symbol hit replaces the held buffer
  always_ff @(posedge clk_net) begin
    if (symbol_now) begin
      buffer_r <= sym_buffer;
    end
  end

  // Output register, one cycle strobe per accepted word
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= word.can_match;
    end
  end

  always_ff @(posedge clk_net) begin
    if (word.can_match) begin
      out_sop    <= word.sop;
      out_eop    <= word.eop;
      out_length <= word.length;
      out_data   <= word.data;
      out_buffer <= buffer_out;
    end
  end

endmodule

`default_nettype wire

// ==== pkt_match_top.sv ====
`default_nettype none

module pkt_match_top (
  input  logic                                                        clk_net,
  input  logic                                                        rst_net,
  // Input word
  input  logic                                                        in_vld,
  input  logic                                                        in_sop,
  input  logic                                                        in_eop,
  input  logic [pkt_match_pkg::len_w-1:0]                             in_length,
  input  pkt_match_pkg::data_word_u                                   in_data,
  // Type operand
  input  logic [pkt_match_pkg::word_off_w-1:0]                        type_word_off,
  input  logic [pkt_match_pkg::byte_off_w-1:0]                        type_byte_off,
  input  logic [pkt_match_pkg::type_w-1:0]                            type_value,
  // Symbol entries, indexed by entry
  input  logic [pkt_match_pkg::num_symbols-1:0]                       sym_valid,
  input  logic [pkt_match_pkg::num_symbols-1:0][pkt_match_pkg::word_off_w-1:0] sym_word_off,
  input  logic [pkt_match_pkg::num_symbols-1:0][pkt_match_pkg::data_w-1:0]     sym_value,
  input  logic [pkt_match_pkg::num_symbols-1:0][pkt_match_pkg::buffer_w-1:0]   sym_buffer,
  // Output word
  output logic                                                        out_vld,
  output logic                                                        out_sop,
  output logic                                                        out_eop,
  output logic [pkt_match_pkg::len_w-1:0]                             out_length,
  output pkt_match_pkg::data_word_u                                   out_data,
  output logic [pkt_match_pkg::buffer_w-1:0]                          out_buffer
);
  import pkt_match_pkg::*;

  logic                type_found;
  logic                sym_found;
  logic [buffer_w-1:0] sel_buffer;

  // Registered word and parse status shared by the datapath
  match_word_if u_word ();

  pkt_parse_ctrl u_ctrl (
    .clk_net   (clk_net),
    .rst_net   (rst_net),
    .in_vld    (in_vld),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_length (in_length),
    .in_data   (in_data),
    .word      (u_word.ctrl)
  );

  type_matcher u_type (
    .clk_net       (clk_net),
    .word          (u_word.matcher),
    .type_word_off (type_word_off),
    .type_byte_off (type_byte_off),
    .type_value    (type_value),
    .type_found    (type_found)
  );

  symbol_matcher u_symbol (
    .clk_net        (clk_net),
    .word           (u_word.matcher),
    .sym_valid      (sym_valid),
    .sym_word_off   (sym_word_off),
    .sym_value      (sym_value),
    .sym_buffer     (sym_buffer),
    .sym_found      (sym_found),
    .sym_buffer_sel (sel_buffer)
  );

  match_tracker u_tracker (
    .clk_net    (clk_net),
    .rst_net    (rst_net),
    .word       (u_word.tracker),
    .type_found (type_found),
    .sym_found  (sym_found),
    .sym_buffer (sel_buffer),
    .out_vld    (out_vld),
    .out_sop    (out_sop),
    .out_eop    (out_eop),
    .out_length (out_length),
    .out_data   (out_data),
    .out_buffer (out_buffer)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk_net,
  output logic rst_net
);
  timeunit 1ns;
  timeprecision 1ns;

  // 100 ns period
  initial begin
    clk_net = 1'b0;
    forever #50 clk_net = ~clk_net;
  end

  // Reset held over 3 rising edges, released with the stimulus delay
  initial begin
    rst_net = 1'b1;
    repeat (3) @(posedge clk_net);
    #10 rst_net = 1'b0;
  end

endmodule

`default_nettype wire

// ==== pkt_match_asserts.sv ====
`default_nettype none

module pkt_match_asserts (
  input logic                                clk_net,
  input logic                                rst_net,
  input logic                                in_vld,
  input logic                                out_vld,
  input logic                                out_eop,
  input logic [pkt_match_pkg::buffer_w-1:0]  out_buffer
);
  timeunit 1ns;
  timeprecision 1ns;

  // Count of assertion failures seen so far
  int fail_count = 0;

  // Output strobe cleared by the synchronous reset
  a_reset_idle: assert property (@(posedge clk_net) rst_net |=> !out_vld)
    else begin
      fail_count++;
      $error("out_vld high after a reset cycle");
    end

  // Buffer only carried on end words
  a_buffer_on_eop: assert property (@(posedge clk_net) disable iff (rst_net)
    out_vld && !out_eop |-> out_buffer == '0)
    else begin
      fail_count++;
      $error("out_buffer nonzero on a word that is not an end word");
    end

  // Every output word needs an input word two cycles earlier
  a_no_spurious: assert property (@(posedge clk_net) disable iff (rst_net)
    !in_vld |-> ##2 !out_vld)
    else begin
      fail_count++;
      $error("out_vld raised without a matching input word");
    end

endmodule

`default_nettype wire

// ==== pkt_match_tb.sv ====
`default_nettype none

module pkt_match_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import pkt_match_pkg::*;

  localparam int clk_period = 100;
  localparam int rand_pkts = 30;
  localparam int max_words = 8;
  localparam int directed_words = 42;
  // Directed words plus the longest possible random traffic
  localparam int total_words = directed_words + rand_pkts * max_words;
  localparam int margin_cycles = 200;

  // One expected output word with the cycle it must show up in
  typedef struct packed {
    int                  cyc;
    logic                sop;
    logic                eop;
    logic [len_w-1:0]    length;
    logic [data_w-1:0]   data;
    logic [buffer_w-1:0] buffer;
  } out_word_t;

  logic                                   clk_net;
  logic                                   rst_net;
  logic                                   in_vld;
  logic                                   in_sop;
  logic                                   in_eop;
  logic [len_w-1:0]                       in_length;
  data_word_u                             in_data;
  logic [word_off_w-1:0]                  type_word_off;
  logic [byte_off_w-1:0]                  type_byte_off;
  logic [type_w-1:0]                      type_value;
  logic [num_symbols-1:0]                 sym_valid;
  logic [num_symbols-1:0][word_off_w-1:0] sym_word_off;
  logic [num_symbols-1:0][data_w-1:0]     sym_value;
  logic [num_symbols-1:0][buffer_w-1:0]   sym_buffer;
  logic                                   out_vld;
  logic                                   out_sop;
  logic                                   out_eop;
  logic [len_w-1:0]                       out_length;
  data_word_u                             out_data;
  logic [buffer_w-1:0]                    out_buffer;

  // Reference model state and operands captured at the start word
  logic                                   m_in_pkt = 1'b0;
  int                                     m_off = 0;
  logic                                   m_got_type = 1'b0;
  logic                                   m_got_sym = 1'b0;
  logic [buffer_w-1:0]                    m_buf = '0;
  int                                     m_type_off;
  int                                     m_type_byte;
  logic [type_w-1:0]                      m_type_val;
  logic [num_symbols-1:0]                 m_sym_valid;
  logic [num_symbols-1:0][word_off_w-1:0] m_sym_off;
  logic [num_symbols-1:0][data_w-1:0]     m_sym_val;
  logic [num_symbols-1:0][buffer_w-1:0]   m_sym_buf;

  out_word_t           exp_q[$];
  logic [data_w-1:0]   pkt_data[$];
  logic [len_w-1:0]    pkt_len[$];
  int                  cyc = 0;
  int                  err_count = 0;
  int                  test_start_errs = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  int                  total_errs;
  string               cur_test = "reset";
  logic [buffer_w-1:0] last_end_buffer;

  tb_clock_gen u_clk (
    .clk_net (clk_net),
    .rst_net (rst_net)
  );

  pkt_match_top uut (.*);

  bind pkt_match_top pkt_match_asserts u_asserts (
    .clk_net    (clk_net),
    .rst_net    (rst_net),
    .in_vld     (in_vld),
    .out_vld    (out_vld),
    .out_eop    (out_eop),
    .out_buffer (out_buffer)
  );

  always @(posedge clk_net) cyc <= cyc + 1;

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  // Output monitor samples mid-cycle where outputs are stable
  always @(negedge clk_net) begin : monitor
    out_word_t w;
    if (out_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("[ERROR] %s: output word appeared with no accepted input word", cur_test);
        err_count++;
      end else begin
        w = exp_q.pop_front();
        check("cycle", w.cyc, cyc);
        check("sop", w.sop, out_sop);
        check("eop", w.eop, out_eop);
        check("length", w.length, out_length);
        check("data", w.data, out_data);
        check("buffer", w.buffer, out_buffer);
        if (out_eop) last_end_buffer = out_buffer;
      end
    end else if (exp_q.size() != 0 && exp_q[0].cyc <= cyc) begin
      $display("[ERROR] %s: expected output word missing in cycle %0d", cur_test, cyc);
      err_count++;
      void'(exp_q.pop_front());
    end
  end

  function automatic logic [data_w-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // Type byte 0 goes to data byte off and bytes past the word end are dropped
  function automatic logic [data_w-1:0] with_type(input logic [data_w-1:0] d, input int off,
                                                  input logic [type_w-1:0] t);
    for (int j = 0; j < type_bytes; j++) begin
      if (off + j < word_bytes) d[8*(off+j) +: 8] = t[8*j +: 8];
    end
    return d;
  endfunction

  // Type hit needs the right word, a legal start and four valid equal bytes
  function automatic logic ref_type(input logic [data_w-1:0] d, input logic [len_w-1:0] len);
    logic hit;
    hit = (m_off == m_type_off) && (m_type_byte <= 4);
    for (int j = 0; j < type_bytes; j++) begin
      if (hit && (m_type_byte + j > len || d[8*(m_type_byte+j) +: 8] != m_type_val[8*j +: 8]))
        hit = 1'b0;
    end
    return hit;
  endfunction

  // Symbol hit on a full word where the highest entry wins
  function automatic logic ref_sym(input logic [data_w-1:0] d, input logic [len_w-1:0] len,
                                   output logic [buffer_w-1:0] sel);
    logic found;
    found = 1'b0;
    sel = '0;
    for (int i = 0; i < num_symbols; i++) begin
      if (m_sym_valid[i] && m_sym_off[i] == m_off && len == 3'd7 && d == m_sym_val[i]) begin
        found = 1'b1;
        sel = m_sym_buf[i];
      end
    end
    return found;
  endfunction

  task automatic send_word(input logic sop, input logic eop, input logic [len_w-1:0] len,
                           input logic [data_w-1:0] d);
    logic                t_hit;
    logic                s_hit;
    logic [buffer_w-1:0] s_buf;
    out_word_t           w;
    @(posedge clk_net);
    #10;
    in_vld = 1'b1;
    in_sop = sop;
    in_eop = eop;
    in_length = len;
    in_data = d;
    // Start word captures operands and restarts the packet state
    if (sop) begin
      m_type_off = type_word_off;
      m_type_byte = type_byte_off;
      m_type_val = type_value;
      m_sym_valid = sym_valid;
      m_sym_off = sym_word_off;
      m_sym_val = sym_value;
      m_sym_buf = sym_buffer;
      m_off = 0;
      m_got_type = 1'b0;
      m_got_sym = 1'b0;
    end
    // Outside a packet only a start word is accepted
    if (m_in_pkt || sop) begin
      t_hit = ref_type(d, len);
      s_hit = ref_sym(d, len, s_buf);
      m_got_type |= t_hit;
      m_got_sym |= s_hit;
      if (s_hit) m_buf = s_buf;
      w.cyc = cyc + 2;
      w.sop = sop;
      w.eop = eop;
      w.length = len;
      w.data = d;
      w.buffer = (eop && m_got_type && m_got_sym) ? m_buf : '0;
      exp_q.push_back(w);
      m_in_pkt = !eop;
      if (!eop) m_off++;
    end
  endtask

  task automatic drain();
    @(posedge clk_net);
    #10;
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_net);
      #10;
    end
  endtask

  task automatic load_packet(input int n);
    pkt_data.delete();
    pkt_len.delete();
    for (int i = 0; i < n; i++) begin
      pkt_data.push_back(rand64());
      pkt_len.push_back(len_full);
    end
  endtask

  task automatic send_packet();
    for (int i = 0; i < pkt_data.size(); i++)
      send_word(i == 0, i == pkt_data.size() - 1, pkt_len[i], pkt_data[i]);
    drain();
  endtask

  // Type placed nowhere legal and all entries off
  task automatic clear_ops();
    type_word_off = '0;
    type_byte_off = 3'd7;
    type_value = '0;
    sym_valid = '0;
    sym_word_off = '0;
    sym_value = '0;
    sym_buffer = '0;
  endtask

  task automatic set_entry(input int e, input int off, input logic [data_w-1:0] value,
                           input logic [buffer_w-1:0] buffer);
    sym_valid[e] = 1'b1;
    sym_word_off[e] = off;
    sym_value[e] = value;
    sym_buffer[e] = buffer;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_start_errs = err_count;
  endtask

  task automatic report_test();
    int n;
    n = err_count - test_start_errs;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("%-12s %s, %0d errors", cur_test, (n == 0) ? "ok" : "mismatch", n);
  endtask

  task automatic pass_through();
    start_test("pass_through");
    clear_ops();
    load_packet(5);
    pkt_len[4] = 3'd5;
    send_packet();
    check("end buffer", 16'h0, last_end_buffer);
    report_test();
  endtask

  task automatic full_match();
    logic [data_w-1:0] sym;
    logic [type_w-1:0] typ;
    start_test("full_match");
    sym = rand64();
    typ = $urandom;
    // Second pass moves the type offset past the last legal start
    for (int pass = 0; pass < 2; pass++) begin
      clear_ops();
      type_word_off = 1;
      type_byte_off = (pass == 0) ? 3'd3 : 3'd5;
      type_value = typ;
      set_entry(1, 2, sym, 16'hb1b1);
      load_packet(4);
      pkt_data[1] = with_type(pkt_data[1], type_byte_off, typ);
      pkt_data[2] = sym;
      send_packet();
      check("end buffer", (pass == 0) ? 16'hb1b1 : 16'h0, last_end_buffer);
    end
    report_test();
  endtask

  task automatic partial_matches();
    logic [data_w-1:0] sym;
    logic [type_w-1:0] typ;
    start_test("partial");
    // Cases are type only, symbol only, entry disabled and short word
    for (int c = 0; c < 4; c++) begin
      sym = rand64();
      typ = $urandom;
      clear_ops();
      type_word_off = 1;
      type_byte_off = 3'd3;
      type_value = typ;
      set_entry(1, 2, sym, 16'hb1b1);
      load_packet(4);
      if (c != 1) pkt_data[1] = with_type(pkt_data[1], 3, typ);
      if (c != 0) pkt_data[2] = sym;
      if (c == 2) sym_valid[1] = 1'b0;
      if (c == 3) pkt_len[2] = 3'd6;
      send_packet();
      check("end buffer", 16'h0, last_end_buffer);
    end
    report_test();
  endtask

  task automatic entry_priority();
    logic [data_w-1:0] sym;
    logic [type_w-1:0] typ;
    start_test("priority");
    sym = rand64();
    typ = $urandom;
    clear_ops();
    type_word_off = 1;
    type_byte_off = 3'd3;
    type_value = typ;
    set_entry(0, 2, sym, 16'h0a0a);
    set_entry(2, 2, sym, 16'h2c2c);
    load_packet(3);
    pkt_data[1] = with_type(pkt_data[1], 3, typ);
    pkt_data[2] = sym;
    send_packet();
    check("end buffer", 16'h2c2c, last_end_buffer);
    // One-word packet whose type is the low half of the symbol
    clear_ops();
    type_byte_off = 3'd0;
    type_value = sym[type_w-1:0];
    set_entry(3, 0, sym, 16'h3d3d);
    load_packet(1);
    pkt_data[0] = sym;
    send_packet();
    check("end buffer", 16'h3d3d, last_end_buffer);
    report_test();
  endtask

  task automatic framing();
    logic [data_w-1:0] sym;
    logic [type_w-1:0] typ;
    start_test("framing");
    clear_ops();
    // Words without a start flag while idle are all dropped
    send_word(1'b0, 1'b0, len_full, rand64());
    send_word(1'b0, 1'b1, len_full, rand64());
    send_word(1'b0, 1'b0, 3'd3, rand64());
    drain();
    sym = rand64();
    typ = $urandom;
    type_word_off = 1;
    type_byte_off = 3'd2;
    type_value = typ;
    set_entry(1, 2, sym, 16'hb1b1);
    load_packet(3);
    pkt_data[1] = with_type(pkt_data[1], 2, typ);
    pkt_data[2] = sym;
    send_packet();
    check("end buffer", 16'hb1b1, last_end_buffer);
    // Same operands with only the type present
    load_packet(3);
    pkt_data[1] = with_type(pkt_data[1], 2, typ);
    send_packet();
    check("end buffer", 16'h0, last_end_buffer);
    report_test();
  endtask

  task automatic random_traffic();
    int n;
    start_test("random");
    for (int p = 0; p < rand_pkts; p++) begin
      type_word_off = $urandom_range(max_words - 1);
      type_byte_off = $urandom_range(7);
      type_value = $urandom;
      for (int e = 0; e < num_symbols; e++) begin
        sym_valid[e] = $urandom_range(1);
        sym_word_off[e] = $urandom_range(max_words - 1);
        sym_value[e] = rand64();
        sym_buffer[e] = $urandom;
      end
      n = $urandom_range(max_words, 1);
      load_packet(n);
      // Plant configured values at their offsets about half the time
      for (int i = 0; i < n; i++) begin
        for (int e = 0; e < num_symbols; e++)
          if (sym_word_off[e] == i && $urandom_range(1)) pkt_data[i] = sym_value[e];
        if (type_word_off == i && $urandom_range(1))
          pkt_data[i] = with_type(pkt_data[i], type_byte_off, type_value);
      end
      pkt_len[n-1] = $urandom_range(7);
      send_packet();
    end
    report_test();
  endtask

  initial begin
    void'($urandom(65));
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_length = '0;
    in_data = '0;
    clear_ops();
    @(negedge rst_net);
    pass_through();
    full_match();
    partial_matches();
    entry_priority();
    framing();
    random_traffic();
    total_errs = err_count + uut.u_asserts.fail_count;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_count, uut.u_asserts.fail_count);
    if (total_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog budget of 4 cycles per word is far above the real pace
  initial begin : watchdog
    #((total_words * 4 + margin_cycles) * clk_period);
    $display("Watchdog expired in test %s before all tests finished", cur_test);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
pkt_match_pkg.sv
match_word_if.sv
pkt_parse_ctrl.sv
type_matcher.sv
symbol_matcher.sv
match_tracker.sv
pkt_match_top.sv
tb_clock_gen.sv
pkt_match_asserts.sv
pkt_match_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_match

sources:
  - files:
      - pkt_match_pkg.sv
      - match_word_if.sv
      - pkt_parse_ctrl.sv
      - type_matcher.sv
      - symbol_matcher.sv
      - match_tracker.sv
      - pkt_match_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - pkt_match_asserts.sv
      - pkt_match_tb.sv
